// File: list.f
verilog/bus_pkg.sv
verilog/bus_arbiter.sv
verilog/bus_regslice.sv
verilog/bus_decoder.sv
verilog/bus.sv
verification/clk_gen.sv
verification/bus_asserts.sv
verification/bus_tb.sv

// File: run.sh
#!/bin/sh
# build and run the bus testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module bus_tb -f list.f -o sim_bus

./obj_dir/sim_bus > sim.log 2>&1 || true
cat sim.log

if grep -q "\*\*\* PASSED \*\*\*" sim.log; then
  exit 0
fi
exit 1

// File: verification/bus_asserts.sv
// ####################################################################
// arbiter handshake assertions
// one owner at a time, single-cycle ready pulses, and no grant
// without a request
// ####################################################################

`timescale 1ns/1ns

module bus_asserts (
  input logic                clk_i,
  input logic                rst_i,
  input logic                core_valid_i,
  input logic                dma_valid_i,
  input logic                core_ready_o,
  input logic                dma_ready_o,
  input logic                grant_ready_i,
  input bus_pkg::arb_state_e state_q
);

  ready_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
    !(core_ready_o && dma_ready_o))
    else $error("core and dma ready high in the same cycle");

  // the slice hands each response back as a single-cycle pulse
  grant_ready_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    grant_ready_i |=> !grant_ready_i)
    else $error("grant ready longer than one cycle");

  // leaving idle needs a request from one of the masters
  idle_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    (state_q == bus_pkg::ARB_IDLE && !core_valid_i && !dma_valid_i)
    |=> (state_q == bus_pkg::ARB_IDLE))
    else $error("arbiter left idle without a valid");

endmodule

bind bus_arbiter bus_asserts u_asserts (
  .clk_i         (clk_i),
  .rst_i         (rst_i),
  .core_valid_i  (core_valid_i),
  .dma_valid_i   (dma_valid_i),
  .core_ready_o  (core_ready_o),
  .dma_ready_o   (dma_ready_o),
  .grant_ready_i (grant_ready_i),
  .state_q       (state_q)
);

// File: verification/bus_cases.txt
# mode addr wdata wstrb target rdata, then the dma request for both/late lines
# target: 0 native, 1 apb, 2 sram, 3 unmapped; mode: core dma both late
core 00000100 00000000 0 0 5A5A0100 0 0 0 0 0
core 10000200 00000000 0 0 4A5A0200 0 0 0 0 0
core 40000300 00000000 0 0 1A5A0300 0 0 0 0 0
core 50000400 00000000 0 0 0A5A0400 0 0 0 0 0
core 60000500 00000000 0 0 3A5A0500 0 0 0 0 0
core 70000600 00000000 0 0 2A5A0600 0 0 0 0 0
core 80000700 00000000 0 0 DA5A0700 0 0 0 0 0
core 90000800 00000000 0 0 CA5A0800 0 0 0 0 0
core 20000900 00000000 0 1 2000ACA5 0 0 0 0 0
core 30000020 00000000 0 2 A5000020 0 0 0 0 0
core 30000010 11223344 3 2 A5000010 0 0 0 0 0
dma 30000010 00000000 0 2 A5003344 0 0 0 0 0
both 10000040 00000000 0 0 4A5A0040 20000080 00000000 0 1 2000A525
late 00001000 00000000 0 0 5A5A1000 30000020 00000000 0 2 A5000020
core 31000000 00000000 0 3 00000000 0 0 0 0 0
dma A0000004 00000000 0 3 00000000 0 0 0 0 0
core 10000010 DEADBEEF F 0 4A5A0010 0 0 0 0 0
both 30000044 CAFEF00D C 2 A5000044 30000044 00000000 0 2 A5000044
core 30000044 00000000 0 2 CAFE0044 0 0 0 0 0

// File: verification/bus_tb.sv
// ####################################################################
// system bus testbench
// drives the core and dma masters from a case file, models the native,
// apb and sram targets, and checks routing, data and arbitration order
// ####################################################################

`timescale 1ns/1ns

module bus_tb;

  logic clk_i;
  logic rst_i;
  logic core_valid_i, dma_valid_i, core_ready_o, dma_ready_o;
  bus_pkg::addr_t core_addr_i, dma_addr_i, natv_addr_o, apb_addr_o;
  bus_pkg::data_t core_wdata_i, dma_wdata_i, core_rdata_o, dma_rdata_o;
  bus_pkg::strb_t core_wstrb_i, dma_wstrb_i, natv_wstrb_o, apb_wstrb_o, ram_wstrb_o;
  logic natv_valid_o, natv_ready_i, apb_valid_o, apb_ready_i;
  bus_pkg::data_t natv_wdata_o, natv_rdata_i, apb_wdata_o, apb_rdata_i;
  bus_pkg::data_t ram_wdata_o, ram_rdata_i;
  bus_pkg::ram_addr_t ram_addr_o;

  bus_pkg::data_t mem [0:32767];
  int natv_cnt, natv_dly, apb_cnt, apb_dly, n_cases;
  bit slow_natv;
  // code of the last target seen (0 native, 1 apb, 2 sram write, 3 none)
  int last_tgt;
  bus_pkg::addr_t last_addr;
  bus_pkg::data_t last_wdata;
  bus_pkg::strb_t last_wstrb;

  clk_gen u_clk (.clk_o(clk_i), .rst_o(rst_i));

  bus dut0 (.*);

  task automatic mismatch(input string msg);
    $display("Mismatch at %0t ns: %s", $time, msg);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_data(input bus_pkg::data_t got, input bus_pkg::data_t exp,
                            input string what);
    if (got !== exp) mismatch($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_addr(input bus_pkg::addr_t got, input bus_pkg::addr_t exp,
                            input string what);
    if (got !== exp) mismatch($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_strb(input bus_pkg::strb_t got, input bus_pkg::strb_t exp,
                            input string what);
    if (got !== exp) mismatch($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) mismatch($sformatf("%s got %b expected %b", what, got, exp));
  endtask

  task automatic check_target(input int got, input int exp);
    if (got != exp) mismatch($sformatf("target got %0d expected %0d", got, exp));
  endtask

  // native and apb models answer after 0 to 3 cycles
  always @(negedge clk_i) begin
    if (natv_ready_i) begin
      natv_ready_i <= 1'b0;
      natv_rdata_i <= '0;
    end else if (natv_valid_o) begin
      if (natv_cnt >= natv_dly) begin
        natv_ready_i <= 1'b1;
        natv_rdata_i <= natv_addr_o ^ 32'h5A5A0000;
        last_tgt   = 0;
        last_addr  = natv_addr_o;
        last_wdata = natv_wdata_o;
        last_wstrb = natv_wstrb_o;
      end else begin
        natv_cnt <= natv_cnt + 1;
      end
    end else begin
      natv_cnt <= 0;
      natv_dly <= slow_natv ? 3 : int'($urandom % 4);
    end
  end

  always @(negedge clk_i) begin
    if (apb_ready_i) begin
      apb_ready_i <= 1'b0;
      apb_rdata_i <= '0;
    end else if (apb_valid_o) begin
      if (apb_cnt >= apb_dly) begin
        apb_ready_i <= 1'b1;
        apb_rdata_i <= apb_addr_o ^ 32'h0000A5A5;
        last_tgt   = 1;
        last_addr  = apb_addr_o;
        last_wdata = apb_wdata_o;
        last_wstrb = apb_wstrb_o;
      end else begin
        apb_cnt <= apb_cnt + 1;
      end
    end else begin
      apb_cnt <= 0;
      apb_dly <= int'($urandom % 4);
    end
  end

  // byte-masked sram with registered read
  always @(posedge clk_i) begin
    for (int b = 0; b < 4; b++) begin
      if (ram_wstrb_o[b]) mem[ram_addr_o][8*b +: 8] <= ram_wdata_o[8*b +: 8];
    end
    ram_rdata_i <= mem[ram_addr_o];
  end

  // monitors sampled mid-cycle on the falling edge
  always @(negedge clk_i) begin
    if (natv_valid_o && apb_valid_o) begin
      $display("native and apb valid were raised together at %0t ns", $time);
      $display("*** FAILED ***");
      $fatal(1);
    end
    if (ram_wstrb_o != '0) begin
      last_tgt   = 2;
      last_addr  = {15'h0, ram_addr_o, 2'b00};
      last_wdata = ram_wdata_o;
      last_wstrb = ram_wstrb_o;
    end
    if (!core_ready_o) check_data(core_rdata_o, '0, "idle core rdata");
    if (!dma_ready_o) check_data(dma_rdata_o, '0, "idle dma rdata");
    if (rst_i) begin
      check_bit(core_ready_o, 1'b0, "core ready in reset");
      check_bit(dma_ready_o, 1'b0, "dma ready in reset");
      check_bit(natv_valid_o, 1'b0, "native valid in reset");
      check_bit(apb_valid_o, 1'b0, "apb valid in reset");
      check_strb(ram_wstrb_o, '0, "sram strobe in reset");
    end
  end

  // one master transfer checked against the expected target and data
  task automatic xfer(input bit is_dma, input bus_pkg::addr_t a, input bus_pkg::data_t w,
                      input bus_pkg::strb_t s, input int tgt, input bus_pkg::data_t exp,
                      output time t_done);
    bus_pkg::data_t rd;
    int got_tgt;
    bit done;
    done = 1'b0;
    @(negedge clk_i);
    if (is_dma) begin
      dma_valid_i = 1'b1;
      dma_addr_i = a;
      dma_wdata_i = w;
      dma_wstrb_i = s;
    end else begin
      core_valid_i = 1'b1;
      core_addr_i = a;
      core_wdata_i = w;
      core_wstrb_i = s;
    end
    while (!done) begin
      @(negedge clk_i);
      if (is_dma ? dma_ready_o : core_ready_o) begin
        rd = is_dma ? dma_rdata_o : core_rdata_o;
        got_tgt = last_tgt;
        last_tgt = 3;
        if (is_dma) dma_valid_i = 1'b0;
        else core_valid_i = 1'b0;
        t_done = $time;
        done = 1'b1;
      end
    end
    // sram reads leave no trace on the port
    check_target(got_tgt, (tgt == 2 && s == '0) ? 3 : tgt);
    if (got_tgt != 3) begin
      check_addr(last_addr, (got_tgt == 2) ? (a & 32'h0001FFFC) : a, "forwarded addr");
      check_data(last_wdata, w, "forwarded wdata");
      check_strb(last_wstrb, s, "forwarded wstrb");
    end
    check_data(rd, exp, is_dma ? "dma rdata" : "core rdata");
  endtask

  initial begin
    int fd;
    int t0, t1;
    string line, mode;
    bus_pkg::addr_t a0, a1;
    bus_pkg::data_t w0, w1, r0, r1;
    bus_pkg::strb_t s0, s1;
    time tc, td;
    void'($urandom(32'h5019));
    core_valid_i = 1'b0;
    core_addr_i = '0;
    core_wdata_i = '0;
    core_wstrb_i = '0;
    dma_valid_i = 1'b0;
    dma_addr_i = '0;
    dma_wdata_i = '0;
    dma_wstrb_i = '0;
    natv_ready_i <= 1'b0;
    natv_rdata_i <= '0;
    apb_ready_i <= 1'b0;
    apb_rdata_i <= '0;
    ram_rdata_i <= '0;
    natv_cnt <= 0;
    natv_dly <= 0;
    apb_cnt <= 0;
    apb_dly <= 0;
    slow_natv = 1'b0;
    last_tgt = 3;
    n_cases = 0;
    for (int i = 0; i < 32768; i++) mem[i] <= 32'hA5000000 ^ (i << 2);
    fd = $fopen("verification/bus_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the case file");
      $display("*** FAILED ***");
      $fatal(1);
    end
    @(negedge rst_i);
    @(negedge clk_i);
    check_bit(core_ready_o, 1'b0, "core ready after reset");
    check_bit(dma_ready_o, 1'b0, "dma ready after reset");
    check_strb(ram_wstrb_o, '0, "sram strobe after reset");
    while ($fgets(line, fd) > 0) begin
      if (line.len() < 4 || line[0] == "#") continue;
      void'($sscanf(line, "%s %h %h %h %d %h %h %h %h %d %h",
                    mode, a0, w0, s0, t0, r0, a1, w1, s1, t1, r1));
      n_cases++;
      if (mode == "core") begin
        xfer(1'b0, a0, w0, s0, t0, r0, tc);
      end else if (mode == "dma") begin
        xfer(1'b1, a0, w0, s0, t0, r0, td);
      end else if (mode == "both") begin
        fork
          xfer(1'b0, a0, w0, s0, t0, r0, tc);
          xfer(1'b1, a1, w1, s1, t1, r1, td);
        join
        if (td >= tc) mismatch("dma did not finish before core on a tie");
      end else begin
        // dma arrives while the core sits on a slow native target
        slow_natv = 1'b1;
        fork
          xfer(1'b0, a0, w0, s0, t0, r0, tc);
          begin
            repeat (2) @(negedge clk_i);
            xfer(1'b1, a1, w1, s1, t1, r1, td);
          end
        join
        slow_natv = 1'b0;
        if (tc >= td) mismatch("dma interrupted the locked core transfer");
      end
    end
    $fclose(fd);
    $display("*** PASSED ***");
    $finish;
  end

  // watchdog allows 20 cycles per case plus the reset time
  initial begin
    #1;
    repeat (10) @(posedge clk_i);
    forever begin
      repeat (20) @(posedge clk_i);
      if ($time > (n_cases * 20 + 10 + 20) * 40) begin
        $display("run timed out waiting for a transfer to complete");
        $display("*** FAILED ***");
        $fatal(1);
      end
    end
  end

endmodule

// File: verification/clk_gen.sv
// ####################################################################
// testbench clock and reset
// 40 ns clock, reset held high for the first 10 cycles
// ####################################################################

`timescale 1ns/1ns

module clk_gen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (10) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

// File: verilog/bus.sv
// ####################################################################
// system bus top
// core and dma masters through the lock arbiter, a register slice and
// the address decoder to the native, apb and sram ports
// ####################################################################

`timescale 1ns/1ns

module bus (
  input  logic               clk_i,
  input  logic               rst_i,
  // core master
  input  logic               core_valid_i,
  input  bus_pkg::addr_t     core_addr_i,
  input  bus_pkg::data_t     core_wdata_i,
  input  bus_pkg::strb_t     core_wstrb_i,
  output logic               core_ready_o,
  output bus_pkg::data_t     core_rdata_o,
  // dma master
  input  logic               dma_valid_i,
  input  bus_pkg::addr_t     dma_addr_i,
  input  bus_pkg::data_t     dma_wdata_i,
  input  bus_pkg::strb_t     dma_wstrb_i,
  output logic               dma_ready_o,
  output bus_pkg::data_t     dma_rdata_o,
  // native peripheral port
  output logic               natv_valid_o,
  output bus_pkg::addr_t     natv_addr_o,
  output bus_pkg::data_t     natv_wdata_o,
  output bus_pkg::strb_t     natv_wstrb_o,
  input  logic               natv_ready_i,
  input  bus_pkg::data_t     natv_rdata_i,
  // apb bridge port
  output logic               apb_valid_o,
  output bus_pkg::addr_t     apb_addr_o,
  output bus_pkg::data_t     apb_wdata_o,
  output bus_pkg::strb_t     apb_wstrb_o,
  input  logic               apb_ready_i,
  input  bus_pkg::data_t     apb_rdata_i,
  // on-chip sram port
  output bus_pkg::ram_addr_t ram_addr_o,
  output bus_pkg::data_t     ram_wdata_o,
  output bus_pkg::strb_t     ram_wstrb_o,
  input  bus_pkg::data_t     ram_rdata_i
);

  // arbiter to slice
  logic           grant_valid;
  bus_pkg::addr_t grant_addr;
  bus_pkg::data_t grant_wdata;
  bus_pkg::strb_t grant_wstrb;
  logic           grant_ready;
  bus_pkg::data_t grant_rdata;

  // slice to decoder
  logic           slv_valid;
  bus_pkg::addr_t slv_addr;
  bus_pkg::data_t slv_wdata;
  bus_pkg::strb_t slv_wstrb;
  logic           slv_ready;
  bus_pkg::data_t slv_rdata;

  bus_arbiter u_arbiter (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .core_valid_i  (core_valid_i),
    .core_addr_i   (core_addr_i),
    .core_wdata_i  (core_wdata_i),
    .core_wstrb_i  (core_wstrb_i),
    .core_ready_o  (core_ready_o),
    .core_rdata_o  (core_rdata_o),
    .dma_valid_i   (dma_valid_i),
    .dma_addr_i    (dma_addr_i),
    .dma_wdata_i   (dma_wdata_i),
    .dma_wstrb_i   (dma_wstrb_i),
    .dma_ready_o   (dma_ready_o),
    .dma_rdata_o   (dma_rdata_o),
    .grant_valid_o (grant_valid),
    .grant_addr_o  (grant_addr),
    .grant_wdata_o (grant_wdata),
    .grant_wstrb_o (grant_wstrb),
    .grant_ready_i (grant_ready),
    .grant_rdata_i (grant_rdata)
  );

  bus_regslice u_regslice (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .up_valid_i (grant_valid),
    .up_addr_i  (grant_addr),
    .up_wdata_i (grant_wdata),
    .up_wstrb_i (grant_wstrb),
    .up_ready_o (grant_ready),
    .up_rdata_o (grant_rdata),
    .dn_valid_o (slv_valid),
    .dn_addr_o  (slv_addr),
    .dn_wdata_o (slv_wdata),
    .dn_wstrb_o (slv_wstrb),
    .dn_ready_i (slv_ready),
    .dn_rdata_i (slv_rdata)
  );

  bus_decoder u_decoder (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .slv_valid_i  (slv_valid),
    .slv_addr_i   (slv_addr),
    .slv_wdata_i  (slv_wdata),
    .slv_wstrb_i  (slv_wstrb),
    .slv_ready_o  (slv_ready),
    .slv_rdata_o  (slv_rdata),
    .natv_valid_o (natv_valid_o),
    .natv_addr_o  (natv_addr_o),
    .natv_wdata_o (natv_wdata_o),
    .natv_wstrb_o (natv_wstrb_o),
    .natv_ready_i (natv_ready_i),
    .natv_rdata_i (natv_rdata_i),
    .apb_valid_o  (apb_valid_o),
    .apb_addr_o   (apb_addr_o),
    .apb_wdata_o  (apb_wdata_o),
    .apb_wstrb_o  (apb_wstrb_o),
    .apb_ready_i  (apb_ready_i),
    .apb_rdata_i  (apb_rdata_i),
    .ram_addr_o   (ram_addr_o),
    .ram_wdata_o  (ram_wdata_o),
    .ram_wstrb_o  (ram_wstrb_o),
    .ram_rdata_i  (ram_rdata_i)
  );

endmodule

// File: verilog/bus_arbiter.sv
// ####################################################################
// bus arbiter
// fixed-priority lock arbiter for the core and dma masters; dma wins
// ties, the owner keeps the bus until its ready pulse, and only the
// owner sees ready and rdata
// ####################################################################

`timescale 1ns/1ns

module bus_arbiter (
  input  logic            clk_i,
  input  logic            rst_i,
  // core master
  input  logic            core_valid_i,
  input  bus_pkg::addr_t  core_addr_i,
  input  bus_pkg::data_t  core_wdata_i,
  input  bus_pkg::strb_t  core_wstrb_i,
  output logic            core_ready_o,
  output bus_pkg::data_t  core_rdata_o,
  // dma master
  input  logic            dma_valid_i,
  input  bus_pkg::addr_t  dma_addr_i,
  input  bus_pkg::data_t  dma_wdata_i,
  input  bus_pkg::strb_t  dma_wstrb_i,
  output logic            dma_ready_o,
  output bus_pkg::data_t  dma_rdata_o,
  // granted request
  output logic            grant_valid_o,
  output bus_pkg::addr_t  grant_addr_o,
  output bus_pkg::data_t  grant_wdata_o,
  output bus_pkg::strb_t  grant_wstrb_o,
  input  logic            grant_ready_i,
  input  bus_pkg::data_t  grant_rdata_i
);

  bus_pkg::arb_state_e state_q;
  bus_pkg::arb_state_e state_d;
  logic                core_own;
  logic                dma_own;

  always_comb begin
    state_d = state_q;
    case (state_q)
      bus_pkg::ARB_IDLE: begin
        // dma first on a tie
        if (dma_valid_i) begin
          state_d = bus_pkg::ARB_DMA;
        end else if (core_valid_i) begin
          state_d = bus_pkg::ARB_CORE;
        end
      end
      bus_pkg::ARB_CORE, bus_pkg::ARB_DMA: begin
        // release once the owner's transfer completes
        if (grant_ready_i) begin
          state_d = bus_pkg::ARB_IDLE;
        end
      end
      default: state_d = bus_pkg::ARB_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= bus_pkg::ARB_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign core_own = (state_q == bus_pkg::ARB_CORE);
  assign dma_own  = (state_q == bus_pkg::ARB_DMA);

  // request mux, nothing goes out while idle
  assign grant_valid_o = (core_own && core_valid_i) || (dma_own && dma_valid_i);
  assign grant_addr_o  = dma_own ? dma_addr_i  : core_addr_i;
  assign grant_wdata_o = dma_own ? dma_wdata_i : core_wdata_i;
  assign grant_wstrb_o = dma_own ? dma_wstrb_i : core_wstrb_i;

  // response steering
  assign core_ready_o = core_own && grant_ready_i;
  assign core_rdata_o = core_own ? grant_rdata_i : '0;
  assign dma_ready_o  = dma_own && grant_ready_i;
  assign dma_rdata_o  = dma_own ? grant_rdata_i : '0;

endmodule

// File: verilog/bus_decoder.sv
// ####################################################################
// bus address decoder
// routes the sliced request to the native, apb or sram port, makes
// the sram ready, and answers unmapped addresses with zero data
// ####################################################################

`timescale 1ns/1ns

module bus_decoder (
  input  logic               clk_i,
  input  logic               rst_i,
  // request from the slice
  input  logic               slv_valid_i,
  input  bus_pkg::addr_t     slv_addr_i,
  input  bus_pkg::data_t     slv_wdata_i,
  input  bus_pkg::strb_t     slv_wstrb_i,
  output logic               slv_ready_o,
  output bus_pkg::data_t     slv_rdata_o,
  // native peripheral port
  output logic               natv_valid_o,
  output bus_pkg::addr_t     natv_addr_o,
  output bus_pkg::data_t     natv_wdata_o,
  output bus_pkg::strb_t     natv_wstrb_o,
  input  logic               natv_ready_i,
  input  bus_pkg::data_t     natv_rdata_i,
  // apb bridge port
  output logic               apb_valid_o,
  output bus_pkg::addr_t     apb_addr_o,
  output bus_pkg::data_t     apb_wdata_o,
  output bus_pkg::strb_t     apb_wstrb_o,
  input  logic               apb_ready_i,
  input  bus_pkg::data_t     apb_rdata_i,
  // on-chip sram port
  output bus_pkg::ram_addr_t ram_addr_o,
  output bus_pkg::data_t     ram_wdata_o,
  output bus_pkg::strb_t     ram_wstrb_o,
  input  bus_pkg::data_t     ram_rdata_i
);

  logic [3:0] top_nib;
  logic [7:0] top_byte;
  logic       natv_sel;
  logic       apb_sel;
  logic       ram_sel;
  logic       unmap_sel;
  logic       ram_valid;
  logic       ram_ready_q;
  logic       unmap_ready_q;
  logic       natv_hit;
  logic       apb_hit;

  assign top_nib  = slv_addr_i[31:28];
  assign top_byte = slv_addr_i[31:24];

  // flash, native ip, sdram, psram and the four sd windows
  assign natv_sel = (top_nib == bus_pkg::FLASH_START)   ||
                    (top_nib == bus_pkg::NATV_IP_START) ||
                    (top_byte == bus_pkg::SDRAM_START)  ||
                    (top_nib == bus_pkg::PSRAM_START)   ||
                    (top_nib == bus_pkg::SPISD_START0)  ||
                    (top_nib == bus_pkg::SPISD_START1)  ||
                    (top_nib == bus_pkg::SPISD_START2)  ||
                    (top_nib == bus_pkg::SPISD_START3);
  assign apb_sel   = (top_nib == bus_pkg::APB_IP_START);
  assign ram_sel   = (top_byte == bus_pkg::SRAM_START);
  assign unmap_sel = !(natv_sel || apb_sel || ram_sel);

  assign natv_valid_o = slv_valid_i && natv_sel;
  assign natv_addr_o  = slv_addr_i;
  assign natv_wdata_o = slv_wdata_i;
  assign natv_wstrb_o = slv_wstrb_i;

  assign apb_valid_o = slv_valid_i && apb_sel;
  assign apb_addr_o  = slv_addr_i;
  assign apb_wdata_o = slv_wdata_i;
  assign apb_wstrb_o = slv_wstrb_i;

  assign ram_valid   = slv_valid_i && ram_sel;
  assign ram_addr_o  = slv_addr_i[bus_pkg::RAM_IDX_MSB:bus_pkg::RAM_IDX_LSB];
  assign ram_wdata_o = slv_wdata_i;
  // write strobe only in the first cycle of an sram access
  assign ram_wstrb_o = (ram_valid && !ram_ready_q) ? slv_wstrb_i : '0;

  // one-cycle responders; a held valid cannot fire ready twice
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ram_ready_q   <= 1'b0;
      unmap_ready_q <= 1'b0;
    end else begin
      ram_ready_q   <= ram_valid && !ram_ready_q;
      unmap_ready_q <= slv_valid_i && unmap_sel && !unmap_ready_q;
    end
  end

  assign natv_hit = natv_valid_o && natv_ready_i;
  assign apb_hit  = apb_valid_o && apb_ready_i;

  assign slv_ready_o = natv_hit || apb_hit || ram_ready_q || unmap_ready_q;
  // unmapped falls through to zero
  assign slv_rdata_o = natv_hit    ? natv_rdata_i :
                       apb_hit     ? apb_rdata_i  :
                       ram_ready_q ? ram_rdata_i  : '0;

endmodule

// File: verilog/bus_pkg.sv
// ####################################################################
// bus package
// widths, address windows and arbiter state shared by the two-master
// system bus (arbiter, register slice and decoder)
// ####################################################################

package bus_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // sram word index comes from these address bits
  localparam int RAM_IDX_LSB = 2;
  localparam int RAM_IDX_MSB = 16;
  localparam int RAM_AW      = RAM_IDX_MSB - RAM_IDX_LSB + 1;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [RAM_AW-1:0] ram_addr_t;

  // windows matched on addr[31:28]
  localparam logic [3:0] FLASH_START   = 4'h0;
  localparam logic [3:0] NATV_IP_START = 4'h1;
  localparam logic [3:0] APB_IP_START  = 4'h2;
  localparam logic [3:0] PSRAM_START   = 4'h5;
  localparam logic [3:0] SPISD_START0  = 4'h6;
  localparam logic [3:0] SPISD_START1  = 4'h7;
  localparam logic [3:0] SPISD_START2  = 4'h8;
  localparam logic [3:0] SPISD_START3  = 4'h9;

  // windows matched on addr[31:24]
  localparam logic [7:0] SRAM_START  = 8'h30;
  localparam logic [7:0] SDRAM_START = 8'h40;

  // arbiter lock state
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_CORE,
    ARB_DMA
  } arb_state_e;

endpackage

// File: verilog/bus_regslice.sv
// ####################################################################
// bus register slice
// registers the request towards the decoder and the response back to
// the arbiter; holds one request at a time
// ####################################################################

`timescale 1ns/1ns

module bus_regslice (
  input  logic            clk_i,
  input  logic            rst_i,
  // upstream, from the arbiter
  input  logic            up_valid_i,
  input  bus_pkg::addr_t  up_addr_i,
  input  bus_pkg::data_t  up_wdata_i,
  input  bus_pkg::strb_t  up_wstrb_i,
  output logic            up_ready_o,
  output bus_pkg::data_t  up_rdata_o,
  // downstream, to the decoder
  output logic            dn_valid_o,
  output bus_pkg::addr_t  dn_addr_o,
  output bus_pkg::data_t  dn_wdata_o,
  output bus_pkg::strb_t  dn_wstrb_o,
  input  logic            dn_ready_i,
  input  bus_pkg::data_t  dn_rdata_i
);

  logic           dn_valid_q;
  logic           up_ready_q;
  logic           dn_done;
  logic           accept;
  bus_pkg::addr_t addr_q;
  bus_pkg::data_t wdata_q;
  bus_pkg::strb_t wstrb_q;
  bus_pkg::data_t rdata_q;

  assign dn_done = dn_valid_q && dn_ready_i;
  // no new request while one is in flight or its response is going back
  assign accept  = up_valid_i && !dn_valid_q && !up_ready_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      dn_valid_q <= 1'b0;
      up_ready_q <= 1'b0;
    end else begin
      if (dn_done) begin
        dn_valid_q <= 1'b0;
      end else if (accept) begin
        dn_valid_q <= 1'b1;
      end
      up_ready_q <= dn_done;
    end
  end

  // payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= up_addr_i;
      wdata_q <= up_wdata_i;
      wstrb_q <= up_wstrb_i;
    end
    // zero outside the response pulse
    rdata_q <= dn_done ? dn_rdata_i : '0;
  end

  assign dn_valid_o = dn_valid_q;
  assign dn_addr_o  = addr_q;
  assign dn_wdata_o = wdata_q;
  assign dn_wstrb_o = wstrb_q;
  assign up_ready_o = up_ready_q;
  assign up_rdata_o = rdata_q;

endmodule
